/* zx_bus_pkg.sv */
/*
 * CPU side types for the ZX Spectrum memory paging core.
 * Holds the sampled Z80 bus request and the ULA output port state.
 * Modules refer to these by scoped name, no import needed.
 */

package zx_bus_pkg;

	// ========================================
	// CPU bus request
	// ========================================

	// Sampled once per clk_sys cycle, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        mreq;
		logic        iorq;
		logic        wr;
	} cpu_req_t;

	// ========================================
	// ULA output port (FE)
	// ========================================

	// Border colour plus the two audio/tape bits
	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_out_t;

	// Bit positions of the ULA port data byte
	localparam int ULA_BORDER_LSB = 0;
	localparam int ULA_MIC_BIT    = 3;
	localparam int ULA_EAR_BIT    = 4;

endpackage

/* zx_mem_pkg.sv */
/*
 * Memory side types for the ZX Spectrum memory paging core.
 * Machine model, the two paging register views, the full paging
 * state, the per-slot mapping result and physical address layout.
 */

package zx_mem_pkg;

	// ========================================
	// Machine model
	// ========================================

	typedef enum logic [1:0] {
		model_48k   = 2'd0,
		model_128k  = 2'd1,
		model_plus3 = 2'd2
	} model_e;

	// ========================================
	// Paging registers
	// ========================================

	// 128K paging port 7FFD
	typedef struct packed {
		logic [1:0] unused;
		logic       lock;
		logic       rom_lo;
		logic       scr;
		logic [2:0] ram_page;
	} page_7ffd_t;

	// +3 paging port 1FFD, upper cfg bit doubles as rom_hi in normal mode
	typedef struct packed {
		logic [4:0] unused;
		logic [1:0] special_cfg;
		logic       special;
	} page_1ffd_t;

	// One written byte, seen through either port layout
	typedef union packed {
		page_7ffd_t as_7ffd;
		page_1ffd_t as_1ffd;
	} page_word_u;

	typedef struct packed {
		model_e     model;
		page_word_u p7ffd;
		page_word_u p1ffd;
		logic       scr_copy;
	} paging_t;

	// ========================================
	// Physical address space
	// ========================================

	// Page number and ROM flag for one 16K CPU window
	typedef struct packed {
		logic [3:0] page;
		logic       rom;
	} slot_map_t;

	typedef logic [24:0] phys_addr_t;

	// ROM images live above the 2M RAM area
	localparam phys_addr_t ROM_BASE = 25'h200000;
	localparam int PAGE_BITS = 14;

endpackage

/* zx_port_decode.sv */
/*
 * I/O write decoder for the paging core.
 * Detects the rising edge of each CPU I/O write, updates the 7FFD and
 * 1FFD paging registers and the ULA port, and latches the machine model
 * while reset is held.
 */

`timescale 1ns/1ps

module zx_port_decode (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_req_t cpu,
	input  zx_mem_pkg::model_e   model,
	output zx_mem_pkg::paging_t  paging,
	output zx_bus_pkg::ula_out_t ula
);

	// ========================================
	// Write strobe edge detection
	// ========================================

	logic io_wr;
	logic io_wr_q;
	logic io_wr_rise;

	assign io_wr      = cpu.iorq & cpu.wr;
	assign io_wr_rise = io_wr & ~io_wr_q;

	// ========================================
	// Port decode
	// ========================================

	logic                   is_48k;
	logic                   is_plus3;
	logic                   locked;
	logic                   sel_7ffd;
	logic                   sel_1ffd;
	logic                   sel_ula;
	zx_mem_pkg::page_word_u wr_word;

	assign is_48k   = (paging.model == zx_mem_pkg::model_48k);
	assign is_plus3 = (paging.model == zx_mem_pkg::model_plus3);
	assign locked   = paging.p7ffd.as_7ffd.lock;

	// Data byte as it would land in either paging register
	assign wr_word = cpu.data;

	// 7FFD: A15 and A1 low, A14 only matters on +3 where 1FFD shares the space
	// The 48K has no paging hardware at all
	assign sel_7ffd = ~cpu.addr[15] & ~cpu.addr[1]
		& (cpu.addr[14] | ~is_plus3)
		& ~locked & ~is_48k;

	// 1FFD: A15..A13 low, A12 high, A1 low, +3 only
	assign sel_1ffd = is_plus3 & ~locked
		& (cpu.addr[15:13] == 3'b000)
		& cpu.addr[12] & ~cpu.addr[1];

	// Any even port reaches the ULA
	assign sel_ula = ~cpu.addr[0];

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// Paging state, model is taken from the input only during reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			paging       <= '0;
			paging.model <= model;
		end else if (io_wr_rise) begin
			if (sel_7ffd) begin
				paging.p7ffd    <= wr_word;
				// Previous screen select is kept for readback
				paging.scr_copy <= paging.p7ffd.as_7ffd.scr;
			end else if (sel_1ffd) begin
				paging.p1ffd <= wr_word;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula <= '0;
		end else if (io_wr_rise && sel_ula) begin
			ula.border <= cpu.data[zx_bus_pkg::ULA_BORDER_LSB +: 3];
			ula.mic    <= cpu.data[zx_bus_pkg::ULA_MIC_BIT];
			ula.ear    <= cpu.data[zx_bus_pkg::ULA_EAR_BIT];
		end
	end

endmodule

/* zx_slot_map.sv */
/*
 * Page lookup for one 16K window of the CPU address space.
 * SLOT selects the window; the output gives the physical page and
 * whether it is ROM. Instantiated once per window by the top level.
 */

`timescale 1ns/1ps

module zx_slot_map #(
	parameter int SLOT = 0
) (
	input  zx_mem_pkg::paging_t   paging,
	output zx_mem_pkg::slot_map_t map
);

	// +3 all-RAM tables, rows are slots, columns special_cfg 0..3
	localparam logic [3:0] SPECIAL_TABLE [0:3][0:3] = '{
		'{4'd0, 4'd4, 4'd4, 4'd4},
		'{4'd1, 4'd5, 4'd5, 4'd7},
		'{4'd2, 4'd6, 4'd6, 4'd6},
		'{4'd3, 4'd7, 4'd3, 4'd3}
	};

	logic       is_48k;
	logic       is_plus3;
	logic       special;
	logic [1:0] special_cfg;
	logic       rom_hi;
	logic       rom_lo;
	logic [3:0] rom_page;

	assign is_48k      = (paging.model == zx_mem_pkg::model_48k);
	assign is_plus3    = (paging.model == zx_mem_pkg::model_plus3);
	assign special     = paging.p1ffd.as_1ffd.special;
	assign special_cfg = paging.p1ffd.as_1ffd.special_cfg;
	assign rom_hi      = special_cfg[1];
	assign rom_lo      = paging.p7ffd.as_7ffd.rom_lo;

	// +3 has four ROMs at pages 4..7, older models two at 2..3
	assign rom_page = is_plus3 ? 4'd4 + {2'b00, rom_hi, rom_lo}
		: 4'd2 + {3'b000, is_48k | rom_lo};

	always_comb begin
		map.rom  = 1'b0;
		map.page = '0;
		if (special) begin
			map.page = SPECIAL_TABLE[SLOT][special_cfg];
		end else begin
			case (SLOT)
				0: begin
					map.rom  = 1'b1;
					map.page = rom_page;
				end
				1: map.page = 4'd5;
				2: map.page = 4'd2;
				default: map.page = {1'b0, paging.p7ffd.as_7ffd.ram_page};
			endcase
		end
	end

endmodule

/* zx_mem_select.sv */
/*
 * Bank selector for the paging core.
 * Picks the slot map by the upper CPU address bits, forms the physical
 * address and the read/write strobes, and registers them so they
 * appear one cycle after the request.
 */

`timescale 1ns/1ps

module zx_mem_select #(
	parameter int SLOT_COUNT = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_bus_pkg::cpu_req_t  cpu,
	input  zx_mem_pkg::slot_map_t maps [SLOT_COUNT],
	output zx_mem_pkg::phys_addr_t ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic                  rom_sel
);

	localparam int SEL_BITS = $clog2(SLOT_COUNT);

	logic [SEL_BITS-1:0]    slot_idx;
	zx_mem_pkg::slot_map_t  cur;
	logic                   writable;
	zx_mem_pkg::phys_addr_t page_base;
	zx_mem_pkg::phys_addr_t offset;
	zx_mem_pkg::phys_addr_t addr_d;
	logic                   rd_d;
	logic                   we_d;

	// ========================================
	// Address translation
	// ========================================

	assign slot_idx = cpu.addr[15 -: SEL_BITS];
	assign cur      = maps[slot_idx];
	assign writable = ~cur.rom;

	assign page_base = zx_mem_pkg::phys_addr_t'(cur.page) << zx_mem_pkg::PAGE_BITS;
	assign offset    = zx_mem_pkg::phys_addr_t'(cpu.addr[zx_mem_pkg::PAGE_BITS-1:0]);

	// ROM pages sit in their own region above RAM
	assign addr_d = cur.rom ? zx_mem_pkg::ROM_BASE + page_base + offset
		: page_base + offset;

	// ROM is never written
	assign rd_d = cpu.mreq & ~cpu.wr;
	assign we_d = cpu.mreq & cpu.wr & writable;

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk_sys) begin
		ram_addr <= addr_d;
		rom_sel  <= cur.rom;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_rd <= 1'b0;
			ram_we <= 1'b0;
		end else begin
			ram_rd <= rd_d;
			ram_we <= we_d;
		end
	end

endmodule

/* zx_memory_map.sv */
/*
 * Top level of the ZX Spectrum memory paging core.
 * The port decoder feeds one slot mapper per 16K window, and the bank
 * selector turns the CPU request into a registered physical access.
 */

`timescale 1ns/1ps

module zx_memory_map #(
	parameter int SLOT_COUNT = 4
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_bus_pkg::cpu_req_t   cpu,
	input  zx_mem_pkg::model_e     model,
	output zx_mem_pkg::phys_addr_t ram_addr,
	output logic                   ram_rd,
	output logic                   ram_we,
	output logic                   rom_sel,
	output zx_bus_pkg::ula_out_t   ula,
	output zx_mem_pkg::paging_t    paging
);

	zx_mem_pkg::slot_map_t maps [SLOT_COUNT];

	// ========================================
	// I/O port decode
	// ========================================

	zx_port_decode u_port_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.model   (model),
		.paging  (paging),
		.ula     (ula)
	);

	// ========================================
	// Slot mappers, one per 16K window
	// ========================================

	for (genvar i = 0; i < SLOT_COUNT; i++) begin : g_slot
		zx_slot_map #(
			.SLOT (i)
		) u_slot_map (
			.paging (paging),
			.map    (maps[i])
		);
	end

	// ========================================
	// Bank select and output register
	// ========================================

	zx_mem_select #(
		.SLOT_COUNT (SLOT_COUNT)
	) u_mem_select (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.maps     (maps),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we),
		.rom_sel  (rom_sel)
	);

endmodule

/* tb_zx_memory_map_ref.svh */
/*
 * Reference model for the memory paging testbench.
 * Included inside the testbench module; works on the testbench's
 * paging state, LFSR and check counters.
 */

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_next(lfsr);
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

// ========================================
// Paging model
// ========================================

// Returns {rom, page} for one 16K window
function automatic logic [4:0] slot_page(input logic [1:0] slot);
	logic [15:0] row;
	logic [3:0]  rom_page;
	if (ref_p1ffd[0]) begin
		// Pages for slots 3..0, one nibble each
		case (ref_p1ffd[2:1])
			2'd0: row = 16'h3210;
			2'd1: row = 16'h7654;
			2'd2: row = 16'h3654;
			default: row = 16'h3674;
		endcase
		return {1'b0, row[slot * 4 +: 4]};
	end
	if (ref_model == 2'd2) begin
		rom_page = 4'd4 + 4'd2 * ref_p1ffd[2] + ref_p7ffd[4];
	end else begin
		rom_page = 4'd2 + ((ref_model == 2'd0 || ref_p7ffd[4]) ? 4'd1 : 4'd0);
	end
	case (slot)
		2'd0: return {1'b1, rom_page};
		2'd1: return {1'b0, 4'd5};
		2'd2: return {1'b0, 4'd2};
		default: return {2'b00, ref_p7ffd[2:0]};
	endcase
endfunction

function automatic logic [24:0] phys_address(input logic [15:0] addr);
	logic [4:0]  m;
	logic [24:0] pa;
	m = slot_page(addr[15:14]);
	pa = 25'(m[3:0]) * 25'd16384 + 25'(addr[13:0]);
	if (m[4]) begin
		pa = pa + 25'h20_0000;
	end
	return pa;
endfunction

function automatic void apply_io_write(input logic [15:0] addr, input logic [7:0] data);
	logic locked;
	logic plus3;
	locked = ref_p7ffd[5];
	plus3  = (ref_model == 2'd2);
	if (!addr[15] && !addr[1] && (addr[14] || !plus3) && !locked && ref_model != 2'd0) begin
		ref_scr_copy = ref_p7ffd[3];
		ref_p7ffd    = data;
	end else if (plus3 && !locked && addr[15:12] == 4'b0001 && !addr[1]) begin
		ref_p1ffd = data;
	end
	if (!addr[0]) begin
		ref_ula = {data[2:0], data[4], data[3]};
	end
endfunction

function automatic logic [18:0] paging_word();
	return {ref_model, ref_p7ffd, ref_p1ffd, ref_scr_copy};
endfunction

// Expected outputs one cycle after req, state updated by its I/O write
function automatic expect_t predict(input zx_bus_pkg::cpu_req_t req);
	expect_t    e;
	logic [4:0] m;
	logic       io_wr;
	e = '0;
	m = slot_page(req.addr[15:14]);
	e.valid    = 1'b1;
	e.chk_addr = req.mreq;
	e.addr     = phys_address(req.addr);
	e.rom      = m[4];
	e.rd       = req.mreq & ~req.wr;
	e.we       = req.mreq & req.wr & ~m[4];
	io_wr = req.iorq & req.wr;
	if (io_wr && !ref_io_prev) begin
		apply_io_write(req.addr, req.data);
	end
	ref_io_prev = io_wr;
	e.paging = paging_word();
	e.ula    = ref_ula;
	return e;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	check_count++;
	if (actual !== expected) begin
		err_count++;
		$display("ERROR %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
	end
endtask

/* tb_zx_memory_map.sv */
/*
 * Testbench for the ZX Spectrum memory paging core.
 * Runs the 48K, 128K, lock, +3, ULA and reset tests against a
 * reference model and checks all outputs one cycle after each request.
 */

`timescale 1ns/1ps

module tb_zx_memory_map;

	localparam int RST_LEN   = 11;
	localparam int TAIL      = 2;
	localparam int N_ACC     = 16;
	localparam int LEN_48K   = RST_LEN + 64 + 2 * 8 + 32 + TAIL;
	localparam int LEN_128K  = RST_LEN + 24 * (2 + N_ACC) + TAIL;
	localparam int LEN_LOCK  = 2 + 8 * (2 + N_ACC) + RST_LEN + 2 + N_ACC + TAIL;
	localparam int LEN_PLUS3 = RST_LEN + 4 * (6 + N_ACC) + 4 * (4 + N_ACC) + TAIL;
	localparam int LEN_ULA   = 2 * 32 + TAIL;
	localparam int LEN_RESET = N_ACC + RST_LEN + TAIL;
	localparam int TIMEOUT_CYCLES = 2 * (LEN_48K + LEN_128K + LEN_LOCK + LEN_PLUS3
		+ LEN_ULA + LEN_RESET + 4);

	typedef struct packed {
		logic        valid;
		logic        in_reset;
		logic        chk_addr;
		logic [24:0] addr;
		logic        rom;
		logic        rd;
		logic        we;
		logic [18:0] paging;
		logic [4:0]  ula;
	} expect_t;

	logic                   clk_sys;
	logic                   reset;
	zx_bus_pkg::cpu_req_t   cpu;
	zx_mem_pkg::model_e     model;
	zx_mem_pkg::phys_addr_t ram_addr;
	logic                   ram_rd;
	logic                   ram_we;
	logic                   rom_sel;
	zx_bus_pkg::ula_out_t   ula;
	zx_mem_pkg::paging_t    paging;

	// Reference paging state
	logic [1:0]  ref_model;
	logic [7:0]  ref_p7ffd;
	logic [7:0]  ref_p1ffd;
	logic        ref_scr_copy;
	logic [4:0]  ref_ula;
	logic        ref_io_prev;
	logic [31:0] lfsr;

	int      check_count;
	int      err_count;
	int      tests_run;
	int      test_checks0;
	int      test_errs0;
	int      cycle_count;
	expect_t exp_next;
	expect_t exp_cur;

	`include "tb_zx_memory_map_ref.svh"

	zx_memory_map #(
		.SLOT_COUNT (4)
	) uut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.model    (model),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we),
		.rom_sel  (rom_sel),
		.ula      (ula),
		.paging   (paging)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	// mode 0 read, 1 write, 2 either
	function automatic zx_bus_pkg::cpu_req_t rand_access(input int mode, input logic slot0);
		zx_bus_pkg::cpu_req_t req;
		logic [31:0]          r;
		req = '0;
		r = rand_bits(16);
		req.addr = slot0 ? {2'b00, r[13:0]} : r[15:0];
		r = rand_bits(8);
		req.data = r[7:0];
		req.mreq = 1'b1;
		r = rand_bits(1);
		req.wr = (mode == 2) ? r[0] : (mode == 1);
		return req;
	endfunction

	task automatic issue(input zx_bus_pkg::cpu_req_t req);
		@(posedge clk_sys);
		#2;
		exp_next = predict(req);
		cpu = req;
	endtask

	// The read right after the write ends the strobe and sees the new mapping
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		issue({addr, data, 1'b0, 1'b1, 1'b1});
		issue(rand_access(0, 1'b0));
	endtask

	task automatic run_accesses(input int n, input int mode, input logic slot0);
		repeat (n) issue(rand_access(mode, slot0));
	endtask

	task automatic apply_reset(input zx_mem_pkg::model_e m);
		expect_t e;
		e = '0;
		e.valid    = 1'b1;
		e.in_reset = 1'b1;
		repeat (RST_LEN - 1) begin
			@(posedge clk_sys);
			#2;
			reset    = 1'b1;
			model    = m;
			cpu      = rand_access(2, 1'b0);
			exp_next = e;
		end
		@(posedge clk_sys);
		#2;
		reset        = 1'b0;
		ref_model    = m;
		ref_p7ffd    = '0;
		ref_p1ffd    = '0;
		ref_scr_copy = 1'b0;
		ref_ula      = '0;
		ref_io_prev  = 1'b0;
		exp_next     = predict('0);
		cpu          = '0;
	endtask

	task automatic finish_test(input string name);
		issue('0);
		issue('0);
		tests_run++;
		$display("Test %s done: %0d checks, %0d errors", name,
			check_count - test_checks0, err_count - test_errs0);
		test_checks0 = check_count;
		test_errs0   = err_count;
	endtask

	// ========================================
	// Compare process
	// ========================================

	always @(posedge clk_sys) begin
		exp_cur <= exp_next;
	end

	// Outputs are settled by the falling edge
	always @(negedge clk_sys) begin
		if (exp_cur.valid) begin
			check_value("ram_rd", exp_cur.rd, ram_rd);
			check_value("ram_we", exp_cur.we, ram_we);
			if (exp_cur.chk_addr) begin
				check_value("ram_addr", exp_cur.addr, ram_addr);
				check_value("rom_sel", exp_cur.rom, rom_sel);
			end
			if (!exp_cur.in_reset) begin
				check_value("paging", exp_cur.paging, paging);
				check_value("ula", exp_cur.ula, ula);
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		reset = 1'b1;
		cpu   = '0;
		model = zx_mem_pkg::model_48k;
		lfsr  = 32'h7b44_c424;
		check_count  = 0;
		err_count    = 0;
		tests_run    = 0;
		test_checks0 = 0;
		test_errs0   = 0;
		exp_next     = '0;
		ref_model    = '0;
		ref_p7ffd    = '0;
		ref_p1ffd    = '0;
		ref_scr_copy = 1'b0;
		ref_ula      = '0;
		ref_io_prev  = 1'b0;

		apply_reset(zx_mem_pkg::model_48k);
		run_accesses(64, 0, 1'b0);
		repeat (8) begin
			d = rand_bits(8);
			io_write(16'h7FFD, d[7:0]);
		end
		run_accesses(32, 1, 1'b0);
		finish_test("48k");

		apply_reset(zx_mem_pkg::model_128k);
		repeat (24) begin
			d = rand_bits(8);
			io_write(16'h7FFD, d[7:0] & 8'hDF);
			run_accesses(N_ACC, 2, 1'b0);
		end
		finish_test("128k");

		// Lock stays until the next reset
		d = rand_bits(8);
		io_write(16'h7FFD, d[7:0] | 8'h20);
		repeat (8) begin
			d = rand_bits(8);
			io_write(16'h7FFD, d[7:0] & 8'hDF);
			run_accesses(N_ACC, 2, 1'b0);
		end
		apply_reset(zx_mem_pkg::model_128k);
		d = rand_bits(8);
		io_write(16'h7FFD, d[7:0] & 8'hDF);
		run_accesses(N_ACC, 2, 1'b0);
		finish_test("lock");

		apply_reset(zx_mem_pkg::model_plus3);
		for (int cfg = 0; cfg < 4; cfg++) begin
			io_write(16'h1FFD, 8'(cfg * 2 + 1));
			run_accesses(N_ACC, 2, 1'b0);
			run_accesses(4, 1, 1'b1);
		end
		for (int rom = 0; rom < 4; rom++) begin
			d = rand_bits(8);
			io_write(16'h1FFD, {5'b00000, rom[1], 2'b00});
			io_write(16'h7FFD, {3'b000, rom[0], d[3:0]});
			run_accesses(N_ACC, 2, 1'b0);
		end
		finish_test("plus3");

		repeat (32) begin
			a = rand_bits(16);
			d = rand_bits(8);
			io_write(a[15:0], d[7:0]);
		end
		finish_test("ula");

		run_accesses(N_ACC, 2, 1'b0);
		apply_reset(zx_mem_pkg::model_plus3);
		finish_test("reset");

		repeat (2) @(posedge clk_sys);
		#1;
		$display("Totals: %0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
		if (err_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* zx_memory_map.f */
+incdir+.
zx_bus_pkg.sv
zx_mem_pkg.sv
zx_port_decode.sv
zx_slot_map.sv
zx_mem_select.sv
zx_memory_map.sv
tb_zx_memory_map.sv

/* Bender.yml */
package:
  name: zx_memory_map

sources:
  - zx_bus_pkg.sv
  - zx_mem_pkg.sv
  - zx_port_decode.sv
  - zx_slot_map.sv
  - zx_mem_select.sv
  - zx_memory_map.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_zx_memory_map.sv
